/* common/exu_defs.svh */
////////////////////
// execute stage constants
// widths and rv64i encoding fields
////////////////////
`ifndef EXU_DEFS_SVH
`define EXU_DEFS_SVH

`define XLEN            64
`define REG_AW          5

// major opcodes
`define OPC_OP_IMM      7'b0010011
`define OPC_OP          7'b0110011
`define OPC_LOAD        7'b0000011
`define OPC_STORE       7'b0100011
`define OPC_BRANCH      7'b1100011
`define OPC_OP_IMM_32   7'b0011011
`define OPC_OP_32       7'b0111011

`define F7_BASE         7'b0000000
`define F7_ALT          7'b0100000  // sub, sra

// alu funct3
`define F3_ADD          3'b000
`define F3_SLL          3'b001
`define F3_SLT          3'b010
`define F3_SLTU         3'b011
`define F3_XOR          3'b100
`define F3_SR           3'b101
`define F3_OR           3'b110
`define F3_AND          3'b111

// branch funct3
`define F3_BEQ          3'b000
`define F3_BNE          3'b001
`define F3_BLT          3'b100
`define F3_BGE          3'b101
`define F3_BLTU         3'b110
`define F3_BGEU         3'b111

`endif

/* common/exu_pkg.sv */
////////////////////
// execute stage types
// data word, alu ops, classes, sizes
////////////////////
`include "exu_defs.svh"

package exu_pkg;

    typedef logic [`XLEN-1:0] xlen_t;

    typedef enum logic [3:0] {
        ALU_NONE = 4'd0,
        ALU_ADD  = 4'd1,
        ALU_SUB  = 4'd2,
        ALU_SLL  = 4'd3,
        ALU_SLT  = 4'd4,
        ALU_SLTU = 4'd5,
        ALU_XOR  = 4'd6,
        ALU_SRL  = 4'd7,
        ALU_SRA  = 4'd8,
        ALU_OR   = 4'd9,
        ALU_AND  = 4'd10
    } alu_op_e;

    typedef enum logic [2:0] {
        CLS_ALU    = 3'd0,
        CLS_LOAD   = 3'd1,
        CLS_STORE  = 3'd2,
        CLS_BRANCH = 3'd3,
        CLS_OTHER  = 3'd4  // unsupported or not handled here
    } ex_class_e;

    // same coding as funct3[1:0] of loads and stores
    typedef enum logic [1:0] {
        SZ_B = 2'd0,
        SZ_H = 2'd1,
        SZ_W = 2'd2,
        SZ_D = 2'd3
    } mem_size_e;

    typedef enum logic [2:0] {
        BR_EQ  = 3'd0,
        BR_NE  = 3'd1,
        BR_LT  = 3'd2,
        BR_GE  = 3'd3,
        BR_LTU = 3'd4,
        BR_GEU = 3'd5
    } br_cond_e;

endpackage

/* hw/exu/ex_decode.sv */
////////////////////
// ex_decode
// instruction class, alu op and immediates
////////////////////
`timescale 1ns/1ps
`include "exu_defs.svh"

module ex_decode (
    input  logic [31:0]         inst_i,
    output exu_pkg::ex_class_e  class_o,
    output exu_pkg::alu_op_e    alu_op_o,
    output logic                word_o,
    output exu_pkg::mem_size_e  size_o,
    output logic                unsigned_ld_o,
    output exu_pkg::br_cond_e   br_cond_o,
    output exu_pkg::xlen_t      imm_s_o,
    output exu_pkg::xlen_t      imm_b_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic [6:0] funct6_x;  // rv64 shift-imm funct6, padded to funct7 width

    assign opcode   = inst_i[6:0];
    assign funct3   = inst_i[14:12];
    assign funct7   = inst_i[31:25];
    assign funct6_x = {inst_i[31:26], 1'b0};

    assign imm_s_o = {{(`XLEN-12){inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
    assign imm_b_o = {{(`XLEN-13){inst_i[31]}}, inst_i[31], inst_i[7],
                      inst_i[30:25], inst_i[11:8], 1'b0};

    function automatic exu_pkg::alu_op_e f3_op(input logic [2:0] f3, input logic alt);
        case (f3)
            `F3_ADD:  f3_op = alt ? exu_pkg::ALU_SUB : exu_pkg::ALU_ADD;
            `F3_SLL:  f3_op = exu_pkg::ALU_SLL;
            `F3_SLT:  f3_op = exu_pkg::ALU_SLT;
            `F3_SLTU: f3_op = exu_pkg::ALU_SLTU;
            `F3_XOR:  f3_op = exu_pkg::ALU_XOR;
            `F3_SR:   f3_op = alt ? exu_pkg::ALU_SRA : exu_pkg::ALU_SRL;
            `F3_OR:   f3_op = exu_pkg::ALU_OR;
            `F3_AND:  f3_op = exu_pkg::ALU_AND;
            default:  f3_op = exu_pkg::ALU_NONE;
        endcase
    endfunction

    always_comb begin
        class_o       = exu_pkg::CLS_OTHER;
        alu_op_o      = exu_pkg::ALU_NONE;
        word_o        = 1'b0;
        size_o        = exu_pkg::SZ_B;
        unsigned_ld_o = 1'b0;
        br_cond_o     = exu_pkg::BR_EQ;

        case (opcode)
            `OPC_OP_IMM: begin
                case (funct3)
                    `F3_SLL: if (funct6_x == `F7_BASE) alu_op_o = exu_pkg::ALU_SLL;
                    `F3_SR: begin
                        if (funct6_x == `F7_BASE || funct6_x == `F7_ALT) begin
                            alu_op_o = f3_op(funct3, inst_i[30]);
                        end
                    end
                    default: alu_op_o = f3_op(funct3, 1'b0);  // no subi
                endcase
            end
            `OPC_OP: begin
                if (funct7 == `F7_BASE ||
                    (funct7 == `F7_ALT && (funct3 == `F3_ADD || funct3 == `F3_SR))) begin
                    alu_op_o = f3_op(funct3, inst_i[30]);
                end
            end
            `OPC_OP_IMM_32: begin
                word_o = 1'b1;
                if (funct3 == `F3_ADD) begin
                    alu_op_o = exu_pkg::ALU_ADD;
                end else if (funct3 == `F3_SLL && funct7 == `F7_BASE) begin
                    alu_op_o = exu_pkg::ALU_SLL;
                end else if (funct3 == `F3_SR &&
                             (funct7 == `F7_BASE || funct7 == `F7_ALT)) begin
                    alu_op_o = f3_op(funct3, inst_i[30]);
                end
            end
            `OPC_OP_32: begin
                word_o = 1'b1;
                if ((funct3 == `F3_ADD || funct3 == `F3_SR) &&
                    (funct7 == `F7_BASE || funct7 == `F7_ALT)) begin
                    alu_op_o = f3_op(funct3, inst_i[30]);
                end else if (funct3 == `F3_SLL && funct7 == `F7_BASE) begin
                    alu_op_o = exu_pkg::ALU_SLL;
                end
            end
            `OPC_LOAD: begin
                if (funct3 != 3'b111) begin  // no ldu
                    class_o       = exu_pkg::CLS_LOAD;
                    size_o        = exu_pkg::mem_size_e'(funct3[1:0]);
                    unsigned_ld_o = funct3[2];
                end
            end
            `OPC_STORE: begin
                if (!funct3[2]) begin
                    class_o = exu_pkg::CLS_STORE;
                    size_o  = exu_pkg::mem_size_e'(funct3[1:0]);
                end
            end
            `OPC_BRANCH: begin
                class_o = exu_pkg::CLS_BRANCH;
                case (funct3)
                    `F3_BEQ:  br_cond_o = exu_pkg::BR_EQ;
                    `F3_BNE:  br_cond_o = exu_pkg::BR_NE;
                    `F3_BLT:  br_cond_o = exu_pkg::BR_LT;
                    `F3_BGE:  br_cond_o = exu_pkg::BR_GE;
                    `F3_BLTU: br_cond_o = exu_pkg::BR_LTU;
                    `F3_BGEU: br_cond_o = exu_pkg::BR_GEU;
                    default:  class_o   = exu_pkg::CLS_OTHER;
                endcase
            end
            default: ;
        endcase

        // any recognised alu encoding
        if (alu_op_o != exu_pkg::ALU_NONE) begin
            class_o = exu_pkg::CLS_ALU;
        end else begin
            word_o = 1'b0;
        end
    end

endmodule

/* hw/exu/int_alu.sv */
////////////////////
// int_alu
// rv64i arithmetic, logic and shifts
////////////////////
`timescale 1ns/1ps
`include "exu_defs.svh"

module int_alu (
    input  exu_pkg::alu_op_e  alu_op_i,
    input  logic              word_i,
    input  exu_pkg::xlen_t    op1_i,
    input  exu_pkg::xlen_t    op2_i,
    output exu_pkg::xlen_t    result_o
);

    exu_pkg::xlen_t res64;
    logic [31:0]    res32;
    logic [5:0]     shamt64;
    logic [4:0]     shamt32;
    logic           lt_s;
    logic           lt_u;

    assign shamt64 = op2_i[5:0];
    assign shamt32 = op2_i[4:0];
    assign lt_s    = $signed(op1_i) < $signed(op2_i);
    assign lt_u    = op1_i < op2_i;

    always_comb begin
        case (alu_op_i)
            exu_pkg::ALU_ADD:  res64 = op1_i + op2_i;
            exu_pkg::ALU_SUB:  res64 = op1_i - op2_i;
            exu_pkg::ALU_SLL:  res64 = op1_i << shamt64;
            exu_pkg::ALU_SLT:  res64 = {{(`XLEN-1){1'b0}}, lt_s};
            exu_pkg::ALU_SLTU: res64 = {{(`XLEN-1){1'b0}}, lt_u};
            exu_pkg::ALU_XOR:  res64 = op1_i ^ op2_i;
            exu_pkg::ALU_SRL:  res64 = op1_i >> shamt64;
            exu_pkg::ALU_SRA:  res64 = $signed(op1_i) >>> shamt64;
            exu_pkg::ALU_OR:   res64 = op1_i | op2_i;
            exu_pkg::ALU_AND:  res64 = op1_i & op2_i;
            default:           res64 = '0;
        endcase
    end

    // word forms work on the low half only
    always_comb begin
        case (alu_op_i)
            exu_pkg::ALU_ADD: res32 = op1_i[31:0] + op2_i[31:0];
            exu_pkg::ALU_SUB: res32 = op1_i[31:0] - op2_i[31:0];
            exu_pkg::ALU_SLL: res32 = op1_i[31:0] << shamt32;
            exu_pkg::ALU_SRL: res32 = op1_i[31:0] >> shamt32;
            exu_pkg::ALU_SRA: res32 = $signed(op1_i[31:0]) >>> shamt32;
            default:          res32 = res64[31:0];
        endcase
    end

    assign result_o = word_i ? {{(`XLEN-32){res32[31]}}, res32} : res64;

endmodule

/* hw/exu/branch_unit.sv */
////////////////////
// branch_unit
// condition compare and branch target
////////////////////
`timescale 1ns/1ps
`include "exu_defs.svh"

module branch_unit (
    input  exu_pkg::br_cond_e  cond_i,
    input  logic               is_branch_i,
    input  exu_pkg::xlen_t     op1_i,
    input  exu_pkg::xlen_t     op2_i,
    input  exu_pkg::xlen_t     pc_i,
    input  exu_pkg::xlen_t     imm_b_i,
    output logic               taken_o,
    output exu_pkg::xlen_t     target_o
);

    logic eq;
    logic lt_s;
    logic lt_u;
    logic cond_met;

    assign eq   = op1_i == op2_i;
    assign lt_s = $signed(op1_i) < $signed(op2_i);
    assign lt_u = op1_i < op2_i;

    always_comb begin
        case (cond_i)
            exu_pkg::BR_EQ:  cond_met = eq;
            exu_pkg::BR_NE:  cond_met = !eq;
            exu_pkg::BR_LT:  cond_met = lt_s;
            exu_pkg::BR_GE:  cond_met = !lt_s;
            exu_pkg::BR_LTU: cond_met = lt_u;
            exu_pkg::BR_GEU: cond_met = !lt_u;
            default:         cond_met = 1'b0;
        endcase
    end

    assign taken_o  = is_branch_i && cond_met;
    assign target_o = taken_o ? pc_i + imm_b_i : {`XLEN{1'b0}};  // zero when not taken

endmodule

/* hw/exu/lsu_agen.sv */
////////////////////
// lsu_agen
// load/store address and store data
////////////////////
`timescale 1ns/1ps
`include "exu_defs.svh"

module lsu_agen (
    input  logic                is_load_i,
    input  logic                is_store_i,
    input  exu_pkg::mem_size_e  size_i,
    input  exu_pkg::xlen_t      base_i,
    input  exu_pkg::xlen_t      imm_load_i,
    input  exu_pkg::xlen_t      imm_s_i,
    input  exu_pkg::xlen_t      store_data_i,
    output logic                mem_ce_o,
    output logic                mem_we_o,
    output exu_pkg::xlen_t      mem_addr_o,
    output exu_pkg::xlen_t      mem_wdata_o
);

    exu_pkg::xlen_t sized_data;

    // zero-extend the low bytes of rs2
    always_comb begin
        case (size_i)
            exu_pkg::SZ_B: sized_data = {{(`XLEN-8){1'b0}}, store_data_i[7:0]};
            exu_pkg::SZ_H: sized_data = {{(`XLEN-16){1'b0}}, store_data_i[15:0]};
            exu_pkg::SZ_W: sized_data = {{(`XLEN-32){1'b0}}, store_data_i[31:0]};
            exu_pkg::SZ_D: sized_data = store_data_i;
            default:       sized_data = '0;
        endcase
    end

    always_comb begin
        mem_ce_o    = is_load_i || is_store_i;
        mem_we_o    = is_store_i;
        mem_addr_o  = '0;
        mem_wdata_o = '0;
        if (is_store_i) begin
            mem_addr_o  = base_i + imm_s_i;
            mem_wdata_o = sized_data;
        end else if (is_load_i) begin
            mem_addr_o  = base_i + imm_load_i;  // reg2 already holds the i-imm
        end
    end

endmodule

/* hw/exu/exu_top.sv */
////////////////////
// exu_top
// rv64i integer execute stage, one
// register stage toward memory
////////////////////
`timescale 1ns/1ps
`include "exu_defs.svh"

module exu_top (
    input  logic                 clk,
    input  logic                 rst_n_i,

    // from decode
    input  logic [31:0]          inst_i,
    input  exu_pkg::xlen_t       inst_addr_i,
    input  exu_pkg::xlen_t       reg1_i,
    input  exu_pkg::xlen_t       reg2_i,  // rs2 or i-imm
    input  logic                 reg_we_i,
    input  logic [`REG_AW-1:0]   reg_waddr_i,

    // writeback
    output logic                 wreg_o,
    output logic [`REG_AW-1:0]   wd_o,
    output exu_pkg::xlen_t       wdata_o,

    // memory
    output logic                 mem_ce_o,
    output logic                 mem_we_o,
    output exu_pkg::xlen_t       mem_addr_o,
    output exu_pkg::xlen_t       mem_wdata_o,
    output exu_pkg::mem_size_e   mem_size_o,

    // redirect
    output logic                 jump_flag_o,
    output exu_pkg::xlen_t       jump_addr_o
);

    exu_pkg::ex_class_e  ex_class;
    exu_pkg::alu_op_e    alu_op;
    logic                word;
    exu_pkg::mem_size_e  size;
    exu_pkg::br_cond_e   br_cond;
    exu_pkg::xlen_t      imm_s;
    exu_pkg::xlen_t      imm_b;
    exu_pkg::xlen_t      alu_result;
    logic                br_taken;
    exu_pkg::xlen_t      br_target;
    logic                agen_ce;
    logic                agen_we;
    exu_pkg::xlen_t      agen_addr;
    exu_pkg::xlen_t      agen_wdata;
    logic                wb_we;
    logic [`REG_AW-1:0]  wb_addr;
    exu_pkg::xlen_t      wb_data;

    ex_decode u_decode (
        .inst_i        (inst_i),
        .class_o       (ex_class),
        .alu_op_o      (alu_op),
        .word_o        (word),
        .size_o        (size),
        .unsigned_ld_o (),  // extension is done in mem
        .br_cond_o     (br_cond),
        .imm_s_o       (imm_s),
        .imm_b_o       (imm_b)
    );

    int_alu u_alu (
        .alu_op_i (alu_op),
        .word_i   (word),
        .op1_i    (reg1_i),
        .op2_i    (reg2_i),
        .result_o (alu_result)
    );

    branch_unit u_branch (
        .cond_i      (br_cond),
        .is_branch_i (ex_class == exu_pkg::CLS_BRANCH),
        .op1_i       (reg1_i),
        .op2_i       (reg2_i),
        .pc_i        (inst_addr_i),
        .imm_b_i     (imm_b),
        .taken_o     (br_taken),
        .target_o    (br_target)
    );

    lsu_agen u_agen (
        .is_load_i    (ex_class == exu_pkg::CLS_LOAD),
        .is_store_i   (ex_class == exu_pkg::CLS_STORE),
        .size_i       (size),
        .base_i       (reg1_i),
        .imm_load_i   (reg2_i),
        .imm_s_i      (imm_s),
        .store_data_i (reg2_i),
        .mem_ce_o     (agen_ce),
        .mem_we_o     (agen_we),
        .mem_addr_o   (agen_addr),
        .mem_wdata_o  (agen_wdata)
    );

    // writeback select by class
    always_comb begin
        wb_we   = reg_we_i;
        wb_addr = reg_waddr_i;
        wb_data = '0;  // loads get their data in mem
        case (ex_class)
            exu_pkg::CLS_ALU: wb_data = alu_result;
            exu_pkg::CLS_STORE, exu_pkg::CLS_BRANCH: begin
                wb_we   = 1'b0;
                wb_addr = '0;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            wreg_o      <= 1'b0;
            wd_o        <= '0;
            wdata_o     <= '0;
            mem_ce_o    <= 1'b0;
            mem_we_o    <= 1'b0;
            mem_addr_o  <= '0;
            mem_wdata_o <= '0;
            mem_size_o  <= exu_pkg::SZ_B;
            jump_flag_o <= 1'b0;
            jump_addr_o <= '0;
        end else begin
            wreg_o      <= wb_we;
            wd_o        <= wb_addr;
            wdata_o     <= wb_data;
            mem_ce_o    <= agen_ce;
            mem_we_o    <= agen_we;
            mem_addr_o  <= agen_addr;
            mem_wdata_o <= agen_wdata;
            mem_size_o  <= size;
            jump_flag_o <= br_taken;
            jump_addr_o <= br_target;
        end
    end

endmodule

/* tests/exu_assert.sv */
////////////////////
// exu_assert
// output rules of the execute stage
////////////////////
`timescale 1ns/1ps

module exu_assert (
    input logic clk,
    input logic rst_n_i,
    input logic wreg_i,
    input logic mem_ce_i,
    input logic mem_we_i,
    input logic jump_flag_i
);

    // a store is always a memory access
    store_has_ce: assert property (@(posedge clk) mem_we_i |-> mem_ce_i)
        else $error("mem_we_o high while mem_ce_o is low");

    store_no_wb: assert property (@(posedge clk) mem_we_i |-> !wreg_i)
        else $error("mem_we_o and wreg_o high together");

    reset_idle: assert property (@(posedge clk)
        !rst_n_i |=> (!jump_flag_i && !mem_ce_i && !wreg_i))
        else $error("control output high one cycle after reset");

endmodule

/* tests/exu_tb.sv */
////////////////////
// exu_tb
// trace-driven testbench for the
// rv64i execute stage
////////////////////
`timescale 1ns/1ps
`include "exu_defs.svh"

module exu_tb;

    localparam int MAX_LINES = 200;  // read loop limit

    logic                clk;
    logic                rst_n_i;
    logic [31:0]         inst_i;
    exu_pkg::xlen_t      inst_addr_i;
    exu_pkg::xlen_t      reg1_i;
    exu_pkg::xlen_t      reg2_i;
    logic                reg_we_i;
    logic [`REG_AW-1:0]  reg_waddr_i;

    logic                wreg_o;
    logic [`REG_AW-1:0]  wd_o;
    exu_pkg::xlen_t      wdata_o;
    logic                mem_ce_o;
    logic                mem_we_o;
    exu_pkg::xlen_t      mem_addr_o;
    exu_pkg::xlen_t      mem_wdata_o;
    exu_pkg::mem_size_e  mem_size_o;
    logic                jump_flag_o;
    exu_pkg::xlen_t      jump_addr_o;

    // trace fields: 0..5 inputs, 6..15 expected outputs
    logic [63:0] fld  [0:15];
    logic [63:0] pend [0:15];
    string       tag;
    string       pend_tag;
    string       skip_txt;
    int          pend_line;
    logic        pending = 1'b0;
    logic        eof_seen = 1'b0;
    int          fd;
    int          rc;
    int          n;
    int          nlines = 0;
    int          checks = 0;
    int          errors = 0;
    int          grp_lines = 0;
    int          grp_checks = 0;
    int          grp_errors = 0;

    exu_top uut (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .inst_i      (inst_i),
        .inst_addr_i (inst_addr_i),
        .reg1_i      (reg1_i),
        .reg2_i      (reg2_i),
        .reg_we_i    (reg_we_i),
        .reg_waddr_i (reg_waddr_i),
        .wreg_o      (wreg_o),
        .wd_o        (wd_o),
        .wdata_o     (wdata_o),
        .mem_ce_o    (mem_ce_o),
        .mem_we_o    (mem_we_o),
        .mem_addr_o  (mem_addr_o),
        .mem_wdata_o (mem_wdata_o),
        .mem_size_o  (mem_size_o),
        .jump_flag_o (jump_flag_o),
        .jump_addr_o (jump_addr_o)
    );

    bind exu_top exu_assert u_assert (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .wreg_i      (wreg_o),
        .mem_ce_i    (mem_ce_o),
        .mem_we_i    (mem_we_o),
        .jump_flag_i (jump_flag_o)
    );

    always #50 clk = ~clk;

    task automatic check_val(input string name, input logic [63:0] exp_v,
                             input logic [63:0] act_v);
        checks++;
        grp_checks++;
        assert (act_v === exp_v) else begin
            $display("mismatch %s (trace line %0d): expected %h, got %h",
                     name, pend_line, exp_v, act_v);
            errors++;
            grp_errors++;
        end
    endtask

    // control outputs stay low in and right after reset
    task automatic check_idle();
        pend_line = 0;
        check_val("wreg_o", 64'h0, 64'(wreg_o));
        check_val("mem_ce_o", 64'h0, 64'(mem_ce_o));
        check_val("mem_we_o", 64'h0, 64'(mem_we_o));
        check_val("jump_flag_o", 64'h0, 64'(jump_flag_o));
    endtask

    task automatic apply_line();
        inst_i      = fld[0][31:0];
        inst_addr_i = fld[1];
        reg1_i      = fld[2];
        reg2_i      = fld[3];
        reg_we_i    = fld[4][0];
        reg_waddr_i = fld[5][`REG_AW-1:0];
    endtask

    task automatic check_line();
        check_val("wreg_o", pend[6], 64'(wreg_o));
        check_val("wd_o", pend[7], 64'(wd_o));
        check_val("wdata_o", pend[8], wdata_o);
        check_val("mem_ce_o", pend[9], 64'(mem_ce_o));
        check_val("mem_we_o", pend[10], 64'(mem_we_o));
        check_val("mem_addr_o", pend[11], mem_addr_o);
        check_val("mem_wdata_o", pend[12], mem_wdata_o);
        check_val("mem_size_o", pend[13], 64'(mem_size_o));
        check_val("jump_flag_o", pend[14], 64'(jump_flag_o));
        check_val("jump_addr_o", pend[15], jump_addr_o);
        grp_lines++;
    endtask

    task automatic report_group(input string name);
        $display("group %s: %0d lines, %0d checks, %0d errors",
                 name, grp_lines, grp_checks, grp_errors);
        grp_lines  = 0;
        grp_checks = 0;
        grp_errors = 0;
    endtask

    initial begin
        clk         = 1'b0;
        rst_n_i     = 1'b0;
        inst_i      = '0;
        inst_addr_i = '0;
        reg1_i      = '0;
        reg2_i      = '0;
        reg_we_i    = 1'b0;
        reg_waddr_i = '0;

        fd = $fopen("tests/exu_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open tests/exu_trace.txt");
            errors++;
            eof_seen = 1'b1;
        end

        // two cycles in reset, then one idle cycle
        for (n = 0; n < 3; n++) begin
            @(negedge clk);
            check_idle();
            if (n == 1) rst_n_i = 1'b1;
        end
        report_group("reset");

        while (!eof_seen && nlines < MAX_LINES) begin
            nlines++;
            rc = $fscanf(fd, "%s", tag);
            if (rc != 1) begin
                eof_seen = 1'b1;
            end else if (tag[0] == 8'h23) begin
                rc = $fgets(skip_txt, fd);  // column notes
            end else begin
                rc = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                             fld[0], fld[1], fld[2], fld[3], fld[4], fld[5],
                             fld[6], fld[7], fld[8], fld[9], fld[10], fld[11],
                             fld[12], fld[13], fld[14], fld[15]);
                if (rc != 16) begin
                    $display("trace line %0d has %0d fields instead of 16", nlines, rc);
                    errors++;
                    eof_seen = 1'b1;
                end else begin
                    @(negedge clk);
                    if (pending) begin
                        check_line();  // previous line, one edge later
                        if (tag != pend_tag) report_group(pend_tag);
                    end
                    apply_line();
                    pend      = fld;
                    pend_tag  = tag;
                    pend_line = nlines;
                    pending   = 1'b1;
                end
            end
        end

        if (!eof_seen) begin
            $display("trace read timed out after %0d lines", MAX_LINES);
            errors++;
        end
        if (pending) begin
            @(negedge clk);
            check_line();
            report_group(pend_tag);
        end

        $display("total: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* tests/exu_trace.txt */
# tag inst pc reg1 reg2 reg_we waddr, then expected wreg wd wdata mem_ce mem_we
# mem_addr mem_wdata mem_size jump_flag jump_addr; all fields hex
alu64 002081b3 1000 7fffffffffffffff 1 1 3 1 3 8000000000000000 0 0 0 0 0 0 0
alu64 402081b3 1000 5 7 1 3 1 3 fffffffffffffffe 0 0 0 0 0 0 0
alu64 002091b3 1000 1 7f 1 3 1 3 8000000000000000 0 0 0 0 0 0 0
alu64 0020a1b3 1000 ffffffffffffffff 1 1 3 1 3 1 0 0 0 0 0 0 0
alu64 0020b1b3 1000 ffffffffffffffff 1 1 3 1 3 0 0 0 0 0 0 0 0
alu64 0020d1b3 1000 8000000000000000 3f 1 3 1 3 1 0 0 0 0 0 0 0
alu64 4020d1b3 1000 8000000000000000 3f 1 3 1 3 ffffffffffffffff 0 0 0 0 0 0 0
alu64 0020f1b3 1000 f0f0 ff00 0 1f 0 1f f000 0 0 0 0 0 0 0
alu64 ffb08193 1000 3 fffffffffffffffb 1 3 1 3 fffffffffffffffe 0 0 0 0 0 0 0
alu64 4040d193 1000 f000000000000010 404 1 3 1 3 ff00000000000001 0 0 0 0 0 0 0
alu64 fff0b193 1000 5 ffffffffffffffff 1 3 1 3 1 0 0 0 0 0 0 0
alu64 fff0a193 1000 5 ffffffffffffffff 1 3 1 3 0 0 0 0 0 0 0 0
alu64 fff0c193 1000 f0f ffffffffffffffff 1 3 1 3 fffffffffffff0f0 0 0 0 0 0 0 0
alu64 0ff0f193 1000 123456789abcdef0 ff 1 3 1 3 f0 0 0 0 0 0 0 0
word 002081bb 1000 7fffffff 1 1 3 1 3 ffffffff80000000 0 0 0 0 0 0 0
word 402081bb 1000 100000000 1 1 3 1 3 ffffffffffffffff 0 0 0 0 0 0 0
word 002091bb 1000 1 3f 1 3 1 3 ffffffff80000000 0 0 0 0 0 0 0
word 0020d1bb 1000 ffffffff80000000 4 1 3 1 3 8000000 0 0 0 0 0 0 0
word 0020d1bb 1000 80000000 40 1 3 1 3 ffffffff80000000 0 0 0 0 0 0 0
word 4020d1bb 1000 80000000 4 1 3 1 3 fffffffff8000000 0 0 0 0 0 0 0
word 0010819b 1000 ffffffff 1 1 3 1 3 0 0 0 0 0 0 0 0
word 01f0919b 1000 3 1f 1 3 1 3 ffffffff80000000 0 0 0 0 0 0 0
word 41f0d19b 1000 80000000 41f 1 3 1 3 ffffffffffffffff 0 0 0 0 0 0 0
load 0080b183 2000 1000 8 1 3 1 3 0 1 0 1008 0 3 0 0
load ffc0a183 2000 2000 fffffffffffffffc 1 5 1 5 0 1 0 1ffc 0 2 0 0
load 0000c183 2000 80000000 0 0 7 0 7 0 1 0 80000000 0 0 0 0
load 0020d183 2000 3000 2 1 3 1 3 0 1 0 3002 0 1 0 0
store 00208823 3000 1000 1122334455667788 1 9 0 0 0 1 1 1010 88 0 0 0
store fe209f23 3000 1000 1122334455667788 1 9 0 0 0 1 1 ffe 7788 1 0 0
store 7e20afa3 3000 1000 1122334455667788 1 9 0 0 0 1 1 17ff 55667788 2 0 0
store 0420b023 3000 1000 1122334455667788 1 9 0 0 0 1 1 1040 1122334455667788 3 0 0
branch 00208863 80000000 5 5 1 4 0 0 0 0 0 0 0 0 1 80000010
branch fe208ce3 100 5 6 1 4 0 0 0 0 0 0 0 0 0 0
branch 00209863 80000000 5 6 1 4 0 0 0 0 0 0 0 0 1 80000010
branch fe209ce3 100 5 5 1 4 0 0 0 0 0 0 0 0 0 0
branch fe20cce3 100 ffffffffffffffff 1 1 4 0 0 0 0 0 0 0 0 1 f8
branch 0020c863 80000000 1 ffffffffffffffff 1 4 0 0 0 0 0 0 0 0 0 0
branch 0020d863 80000000 1 ffffffffffffffff 1 4 0 0 0 0 0 0 0 0 1 80000010
branch fe20dce3 100 ffffffffffffffff 1 1 4 0 0 0 0 0 0 0 0 0 0
branch fe20ece3 100 1 ffffffffffffffff 1 4 0 0 0 0 0 0 0 0 1 f8
branch 0020e863 80000000 ffffffffffffffff 1 1 4 0 0 0 0 0 0 0 0 0 0
branch 0020f863 80000000 ffffffffffffffff 1 1 4 0 0 0 0 0 0 0 0 1 80000010
branch fe20fce3 100 1 ffffffffffffffff 1 4 0 0 0 0 0 0 0 0 0 0

/* filelist.f */
+incdir+common
common/exu_pkg.sv
hw/exu/ex_decode.sv
hw/exu/int_alu.sv
hw/exu/branch_unit.sv
hw/exu/lsu_agen.sv
hw/exu/exu_top.sv
tests/exu_assert.sv
tests/exu_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the execute-stage testbench with verilator, run it, scan the log
cd "$(dirname "$0")" &&
rm -f sim.log &&
verilator --binary --timing --assert -f filelist.f --top-module exu_tb \
    > build.log 2>&1 &&
{ ./obj_dir/Vexu_tb > sim.log 2>&1 || true; } &&
! grep -q "Test failed" sim.log &&
grep -q "Test passed" sim.log &&
echo "simulation ok, see sim.log" ||
{ echo "simulation or build reported errors, see build.log and sim.log"; exit 1; }
